/* include/spi2gpio_params.svh */
/*
 * spi to gpio bridge constants
 * byte widths, register address map, dummy byte and port reset values
 */
`ifndef SPI2GPIO_PARAMS_SVH
`define SPI2GPIO_PARAMS_SVH

// spi framing
`define SPI_BYTE_W	8
`define REG_ADDR_W	6
`define SPI_DUMMY	8'h5A

// one gpio port
`define GPIO_W		8

// port base addresses
`define GPA_BASE	6'h00
`define GPB_BASE	6'h04
`define GPC_BASE	6'h08
`define GPZ_BASE	6'h1C

// register offsets inside a port
`define OFS_OE		6'd0
`define OFS_OUT		6'd1
`define OFS_IN		6'd2

// port z comes up with bit 7 driven high
`define GPZ_OE_RST	8'h80
`define GPZ_OUT_RST	8'h80

`endif

/* rtl/spi2gpio_pkg.sv */
/*
 * spi to gpio shared types
 * command view, received byte event, register request and port drive
 */
`include "spi2gpio_params.svh"

package spi2gpio_pkg;

	// command byte layout
	typedef struct packed {
		logic                   wr;
		logic                   rsvd;
		logic [`REG_ADDR_W-1:0] addr;
	} spi_cmd_t;

	// same byte seen as command or as data
	// which view is valid depends on the phase
	typedef union packed {
		spi_cmd_t               cmd;
		logic [`SPI_BYTE_W-1:0] data;
	} spi_byte_u;

	// one received byte
	// done is a single clk strobe
	typedef struct packed {
		logic      done;
		spi_byte_u rx;
	} spi_rx_t;

	// register access from the decoder
	typedef struct packed {
		logic                   wr;
		logic                   rd;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`SPI_BYTE_W-1:0] wdata;
	} reg_req_t;

	// driven side of a port
	typedef struct packed {
		logic [`GPIO_W-1:0] oe;
		logic [`GPIO_W-1:0] out;
	} gpio_port_t;

endpackage

/* rtl/spi_byte_shifter.sv */
/*
 * spi byte shifter
 * samples the spi pins in the clk domain and moves bytes in and out msb first
 */
`include "spi2gpio_params.svh"

module spi_byte_shifter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_spi_sclk,
	input  logic                   i_spi_cs_n,
	input  logic                   i_spi_mosi,
	input  logic [`SPI_BYTE_W-1:0] i_tx_byte,
	input  logic                   i_tx_load,
	output logic                   o_spi_miso,
	output spi2gpio_pkg::spi_rx_t  o_rx
);

	// first sampling stage
	logic sclk_s;
	logic cs_n_s;
	logic mosi_s;
	// delayed copies for edges
	logic sclk_d;
	logic cs_n_d;

	logic sclk_rise;
	logic frame_start;

	// one hot, top bit means byte complete
	logic [`SPI_BYTE_W:0]   bit_cnt;
	logic [`SPI_BYTE_W-1:0] shift_q;

	logic                    done_q;
	spi2gpio_pkg::spi_byte_u rx_byte;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_s <= 1'b0;
			cs_n_s <= 1'b1;
			mosi_s <= 1'b0;
			sclk_d <= 1'b0;
			cs_n_d <= 1'b1;
		end else begin
			sclk_s <= i_spi_sclk;
			cs_n_s <= i_spi_cs_n;
			mosi_s <= i_spi_mosi;
			sclk_d <= sclk_s;
			cs_n_d <= cs_n_s;
		end
	end

	// rising sclk only counts inside a frame
	assign sclk_rise   = sclk_s & ~sclk_d & ~cs_n_s;
	assign frame_start = cs_n_d & ~cs_n_s;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= 1;
		end else if (frame_start || bit_cnt[`SPI_BYTE_W]) begin
			// restart for a new frame or the next byte
			bit_cnt <= 1;
		end else if (sclk_rise) begin
			bit_cnt <= {bit_cnt[`SPI_BYTE_W-1:0], 1'b0};
		end
	end

	// holds dummy out of reset so the first command byte sends it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= `SPI_DUMMY;
		end else if (i_tx_load) begin
			shift_q <= i_tx_byte;
		end else if (sclk_rise) begin
			// mosi in at the bottom, miso leaves from the top
			shift_q <= {shift_q[`SPI_BYTE_W-2:0], mosi_s};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else begin
			done_q <= bit_cnt[`SPI_BYTE_W];
		end
	end

	// byte snapshot taken with the done strobe
	always_ff @(posedge clk) begin
		if (bit_cnt[`SPI_BYTE_W]) begin
			rx_byte.data <= shift_q;
		end
	end

	assign o_rx = '{done: done_q, rx: rx_byte};

	// quiet line while not selected
	assign o_spi_miso = ~cs_n_s & shift_q[`SPI_BYTE_W-1];

endmodule

/* rtl/spi_cmd_decoder.sv */
/*
 * spi command decoder
 * alternates command and data bytes and issues register strobes
 */
`include "spi2gpio_params.svh"

module spi_cmd_decoder (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_spi_cs_n,
	input  spi2gpio_pkg::spi_rx_t  i_rx,
	output spi2gpio_pkg::reg_req_t o_req,
	output logic                   o_data_phase
);

	// own copy of chip select for the deselect edge
	logic cs_n_s;
	logic cs_n_d;
	logic cs_rise;

	// 0 command, 1 data
	logic phase_q;

	// pending command
	logic                   pend_wr;
	logic [`REG_ADDR_W-1:0] pend_addr;

	logic                   wr_q;
	logic                   rd_q;
	logic [`REG_ADDR_W-1:0] addr_q;
	logic [`SPI_BYTE_W-1:0] wdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_n_s <= 1'b1;
			cs_n_d <= 1'b1;
		end else begin
			cs_n_s <= i_spi_cs_n;
			cs_n_d <= cs_n_s;
		end
	end

	assign cs_rise = cs_n_s & ~cs_n_d;

	// deselect wins over a byte
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= 1'b0;
		end else if (cs_rise) begin
			phase_q <= 1'b0;
		end else if (i_rx.done) begin
			phase_q <= ~phase_q;
		end
	end

	// strobes, one clk after done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_q    <= 1'b0;
			rd_q    <= 1'b0;
			pend_wr <= 1'b0;
		end else begin
			wr_q <= i_rx.done & phase_q & pend_wr;
			rd_q <= i_rx.done & ~phase_q & ~i_rx.rx.cmd.wr;
			if (i_rx.done && !phase_q) begin
				pend_wr <= i_rx.rx.cmd.wr;
			end
		end
	end

	// address and data payload
	always_ff @(posedge clk) begin
		if (i_rx.done) begin
			if (!phase_q) begin
				pend_addr <= i_rx.rx.cmd.addr;
				addr_q    <= i_rx.rx.cmd.addr;
			end else begin
				addr_q  <= pend_addr;
				wdata_q <= i_rx.rx.data;
			end
		end
	end

	assign o_req        = '{wr: wr_q, rd: rd_q, addr: addr_q, wdata: wdata_q};
	assign o_data_phase = phase_q;

endmodule

/* rtl/gpio_regfile.sv */
/*
 * gpio register file
 * port enable and output registers plus read-back into the transmit byte
 */
`include "spi2gpio_params.svh"

module gpio_regfile (
	input  logic                     clk,
	input  logic                     rst_n,
	input  spi2gpio_pkg::reg_req_t   i_req,
	input  logic                     i_data_phase,
	input  logic [`GPIO_W-1:0]       i_gpa_in,
	input  logic [`GPIO_W-1:0]       i_gpb_in,
	input  logic [`GPIO_W-1:0]       i_gpc_in,
	input  logic [`GPIO_W-1:0]       i_gpz_in,
	output spi2gpio_pkg::gpio_port_t o_gpa,
	output spi2gpio_pkg::gpio_port_t o_gpb,
	output spi2gpio_pkg::gpio_port_t o_gpc,
	output spi2gpio_pkg::gpio_port_t o_gpz,
	output logic [`SPI_BYTE_W-1:0]   o_tx_byte,
	output logic                     o_tx_load
);

	spi2gpio_pkg::gpio_port_t gpa_q;
	spi2gpio_pkg::gpio_port_t gpb_q;
	spi2gpio_pkg::gpio_port_t gpc_q;
	spi2gpio_pkg::gpio_port_t gpz_q;

	// phase history for the end of a data byte
	logic phase_d;
	logic dummy_reload;

	logic [`SPI_BYTE_W-1:0] rd_val;
	logic [`SPI_BYTE_W-1:0] tx_q;
	logic                   load_q;

	// input and unmapped addresses fall to default
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gpa_q <= '0;
			gpb_q <= '0;
			gpc_q <= '0;
			gpz_q <= '{oe: `GPZ_OE_RST, out: `GPZ_OUT_RST};
		end else if (i_req.wr) begin
			case (i_req.addr)
				`GPA_BASE + `OFS_OE:  gpa_q.oe  <= i_req.wdata;
				`GPA_BASE + `OFS_OUT: gpa_q.out <= i_req.wdata;
				`GPB_BASE + `OFS_OE:  gpb_q.oe  <= i_req.wdata;
				`GPB_BASE + `OFS_OUT: gpb_q.out <= i_req.wdata;
				`GPC_BASE + `OFS_OE:  gpc_q.oe  <= i_req.wdata;
				`GPC_BASE + `OFS_OUT: gpc_q.out <= i_req.wdata;
				`GPZ_BASE + `OFS_OE:  gpz_q.oe  <= i_req.wdata;
				`GPZ_BASE + `OFS_OUT: gpz_q.out <= i_req.wdata;
				default: ;
			endcase
		end
	end

	// read mux, input registers show the live pins
	always_comb begin
		case (i_req.addr)
			`GPA_BASE + `OFS_OE:  rd_val = gpa_q.oe;
			`GPA_BASE + `OFS_OUT: rd_val = gpa_q.out;
			`GPA_BASE + `OFS_IN:  rd_val = i_gpa_in;
			`GPB_BASE + `OFS_OE:  rd_val = gpb_q.oe;
			`GPB_BASE + `OFS_OUT: rd_val = gpb_q.out;
			`GPB_BASE + `OFS_IN:  rd_val = i_gpb_in;
			`GPC_BASE + `OFS_OE:  rd_val = gpc_q.oe;
			`GPC_BASE + `OFS_OUT: rd_val = gpc_q.out;
			`GPC_BASE + `OFS_IN:  rd_val = i_gpc_in;
			`GPZ_BASE + `OFS_OE:  rd_val = gpz_q.oe;
			`GPZ_BASE + `OFS_OUT: rd_val = gpz_q.out;
			`GPZ_BASE + `OFS_IN:  rd_val = i_gpz_in;
			default:              rd_val = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_d <= 1'b0;
		end else begin
			phase_d <= i_data_phase;
		end
	end

	// data byte done or frame dropped in the data phase
	assign dummy_reload = phase_d & ~i_data_phase;

	// transmit byte and its load strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_q   <= `SPI_DUMMY;
			load_q <= 1'b0;
		end else begin
			load_q <= i_req.rd | dummy_reload;
			if (i_req.rd) begin
				tx_q <= rd_val;
			end else if (dummy_reload) begin
				tx_q <= `SPI_DUMMY;
			end
		end
	end

	assign o_gpa     = gpa_q;
	assign o_gpb     = gpb_q;
	assign o_gpc     = gpc_q;
	assign o_gpz     = gpz_q;
	assign o_tx_byte = tx_q;
	assign o_tx_load = load_q;

endmodule

/* rtl/spi2gpio.sv */
/*
 * spi to gpio bridge top
 * byte shifter, command decoder and register file for ports a b c z
 */
`include "spi2gpio_params.svh"

module spi2gpio (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_spi_sclk,
	input  logic                     i_spi_cs_n,
	input  logic                     i_spi_mosi,
	output logic                     o_spi_miso,
	input  logic [`GPIO_W-1:0]       i_gpa_in,
	input  logic [`GPIO_W-1:0]       i_gpb_in,
	input  logic [`GPIO_W-1:0]       i_gpc_in,
	input  logic [`GPIO_W-1:0]       i_gpz_in,
	output spi2gpio_pkg::gpio_port_t o_gpa,
	output spi2gpio_pkg::gpio_port_t o_gpb,
	output spi2gpio_pkg::gpio_port_t o_gpc,
	output spi2gpio_pkg::gpio_port_t o_gpz
);

	// shifter to decoder
	spi2gpio_pkg::spi_rx_t  rx;
	// decoder to register file
	spi2gpio_pkg::reg_req_t req;
	logic                   data_phase;
	// register file back to shifter
	logic [`SPI_BYTE_W-1:0] tx_byte;
	logic                   tx_load;

	spi_byte_shifter shifter0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_spi_sclk (i_spi_sclk),
		.i_spi_cs_n (i_spi_cs_n),
		.i_spi_mosi (i_spi_mosi),
		.i_tx_byte  (tx_byte),
		.i_tx_load  (tx_load),
		.o_spi_miso (o_spi_miso),
		.o_rx       (rx)
	);

	spi_cmd_decoder decoder0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_spi_cs_n   (i_spi_cs_n),
		.i_rx         (rx),
		.o_req        (req),
		.o_data_phase (data_phase)
	);

	gpio_regfile regfile0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_req        (req),
		.i_data_phase (data_phase),
		.i_gpa_in     (i_gpa_in),
		.i_gpb_in     (i_gpb_in),
		.i_gpc_in     (i_gpc_in),
		.i_gpz_in     (i_gpz_in),
		.o_gpa        (o_gpa),
		.o_gpb        (o_gpb),
		.o_gpc        (o_gpc),
		.o_gpz        (o_gpz),
		.o_tx_byte    (tx_byte),
		.o_tx_load    (tx_load)
	);

endmodule

/* test/tb_spi2gpio.sv */
/*
 * spi2gpio testbench
 * file driven spi master, checks read data, miso and the port drive
 */
`include "spi2gpio_params.svh"

module tb_spi2gpio;

	localparam int MAX_LINES = 64;
	// op addr value miso a_in b_in c_in z_in
	localparam int COLS      = 8;
	localparam int TIMEOUT   = 100;

	logic clk;
	logic rst_n;
	logic spi_sclk;
	logic spi_cs_n;
	logic spi_mosi;
	logic spi_miso;
	logic [`GPIO_W-1:0] gpa_in;
	logic [`GPIO_W-1:0] gpb_in;
	logic [`GPIO_W-1:0] gpc_in;
	logic [`GPIO_W-1:0] gpz_in;
	spi2gpio_pkg::gpio_port_t gpa;
	spi2gpio_pkg::gpio_port_t gpb;
	spi2gpio_pkg::gpio_port_t gpc;
	spi2gpio_pkg::gpio_port_t gpz;

	logic [7:0] stim [0:MAX_LINES*COLS-1];

	// expected drive of ports a b c z at index 0 to 3
	logic [7:0] exp_oe  [0:3];
	logic [7:0] exp_out [0:3];

	int mismatches;
	int timeouts;
	int other_errors;

	spi2gpio dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_spi_sclk (spi_sclk),
		.i_spi_cs_n (spi_cs_n),
		.i_spi_mosi (spi_mosi),
		.o_spi_miso (spi_miso),
		.i_gpa_in   (gpa_in),
		.i_gpb_in   (gpb_in),
		.i_gpc_in   (gpc_in),
		.i_gpz_in   (gpz_in),
		.o_gpa      (gpa),
		.o_gpb      (gpb),
		.o_gpc      (gpc),
		.o_gpz      (gpz)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Fail at %0t: %s is %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	// port number from the address map or -1 when unmapped
	function automatic int port_index(input logic [5:0] addr);
		case ({addr[5:2], 2'b00})
			`GPA_BASE: port_index = 0;
			`GPB_BASE: port_index = 1;
			`GPC_BASE: port_index = 2;
			`GPZ_BASE: port_index = 3;
			default:   port_index = -1;
		endcase
	endfunction

	// only oe and out offsets are writable
	function automatic void apply_write(input logic [5:0] addr, input logic [7:0] val);
		int p;
		p = port_index(addr);
		if (p >= 0 && {4'b0, addr[1:0]} == `OFS_OE)
			exp_oe[p] = val;
		if (p >= 0 && {4'b0, addr[1:0]} == `OFS_OUT)
			exp_out[p] = val;
	endfunction

	function automatic logic ports_match();
		ports_match = gpa.oe == exp_oe[0] && gpa.out == exp_out[0] &&
			gpb.oe == exp_oe[1] && gpb.out == exp_out[1] &&
			gpc.oe == exp_oe[2] && gpc.out == exp_out[2] &&
			gpz.oe == exp_oe[3] && gpz.out == exp_out[3];
	endfunction

	task automatic check_ports();
		check_value("o_gpa.oe", gpa.oe, exp_oe[0]);
		check_value("o_gpa.out", gpa.out, exp_out[0]);
		check_value("o_gpb.oe", gpb.oe, exp_oe[1]);
		check_value("o_gpb.out", gpb.out, exp_out[1]);
		check_value("o_gpc.oe", gpc.oe, exp_oe[2]);
		check_value("o_gpc.out", gpc.out, exp_out[2]);
		check_value("o_gpz.oe", gpz.oe, exp_oe[3]);
		check_value("o_gpz.out", gpz.out, exp_out[3]);
	endtask

	// ports sampled on the falling clk edge
	task automatic wait_ports();
		int n;
		n = 0;
		@(negedge clk);
		while (!ports_match() && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!ports_match()) begin
			timeouts++;
			$display("timeout: port outputs never reached the expected values");
		end
		check_ports();
	endtask

	// mode 0 byte with miso taken just before each rising sclk
	task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk);
			spi_sclk <= 1'b0;
			spi_mosi <= tx[i];
			repeat (3) @(posedge clk);
			@(negedge clk);
			rx[i] = spi_miso;
			@(posedge clk);
			spi_sclk <= 1'b1;
			repeat (3) @(posedge clk);
		end
		@(posedge clk);
		spi_sclk <= 1'b0;
		// gap for the read turnaround
		repeat (10) @(posedge clk);
	endtask

	task automatic frame_begin();
		@(posedge clk);
		spi_cs_n <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic frame_end();
		@(posedge clk);
		spi_cs_n <= 1'b1;
		spi_mosi <= 1'b0;
		repeat (6) @(posedge clk);
	endtask

	task automatic run_line(input int base);
		logic [7:0] op;
		logic [5:0] addr;
		logic [7:0] val;
		logic [7:0] miso_exp;
		logic [7:0] cmd_rx;
		logic [7:0] data_rx;
		op       = stim[base];
		addr     = stim[base + 1][5:0];
		val      = stim[base + 2];
		miso_exp = stim[base + 3];
		case (op)
			8'h00: begin
				frame_begin();
				shift_byte({1'b1, 1'b0, addr}, cmd_rx);
				shift_byte(val, data_rx);
				frame_end();
				check_value("o_spi_miso command", cmd_rx, miso_exp);
				apply_write(addr, val);
				wait_ports();
			end
			8'h01: begin
				frame_begin();
				shift_byte({1'b0, 1'b0, addr}, cmd_rx);
				shift_byte(8'h00, data_rx);
				frame_end();
				check_value("o_spi_miso command", cmd_rx, miso_exp);
				check_value($sformatf("o_spi_miso read %02h", addr), data_rx, val);
			end
			8'h02: begin
				// write command then deselect with no data byte
				frame_begin();
				shift_byte({1'b1, 1'b0, addr}, cmd_rx);
				frame_end();
				check_value("o_spi_miso command", cmd_rx, miso_exp);
				wait_ports();
			end
			8'h03: begin
				@(posedge clk);
				gpa_in <= stim[base + 4];
				gpb_in <= stim[base + 5];
				gpc_in <= stim[base + 6];
				gpz_in <= stim[base + 7];
			end
			default: begin
				other_errors++;
				$display("unknown operation %02h in stimulus line %0d", op, base / COLS);
			end
		endcase
	endtask

	initial begin
		int line;
		rst_n        = 1'b0;
		spi_sclk     = 1'b0;
		spi_cs_n     = 1'b1;
		spi_mosi     = 1'b0;
		gpa_in       = '0;
		gpb_in       = '0;
		gpc_in       = '0;
		gpz_in       = '0;
		mismatches   = 0;
		timeouts     = 0;
		other_errors = 0;
		for (int p = 0; p < 3; p++) begin
			exp_oe[p]  = 8'h00;
			exp_out[p] = 8'h00;
		end
		exp_oe[3]  = `GPZ_OE_RST;
		exp_out[3] = `GPZ_OUT_RST;
		$readmemh("test/spi2gpio_stimulus.txt", stim);

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_ports();

		line = 0;
		while (line < MAX_LINES && stim[line * COLS] !== 8'hFF &&
			!$isunknown(stim[line * COLS])) begin
			run_line(line * COLS);
			line++;
		end
		// a missing file or a missing end line both leave no ff marker
		if (line >= MAX_LINES || stim[line * COLS] !== 8'hFF) begin
			other_errors++;
			$display("stimulus file is missing or has no end line");
		end

		$display("%0d lines run, %0d mismatches, %0d timeouts, %0d other errors",
			line, mismatches, timeouts, other_errors);
		if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* test/spi2gpio_stimulus.txt */
// op addr value miso_cmd gpa_in gpb_in gpc_in gpz_in, all hex
// op 00 write, 01 read (value is expected), 02 abort, 03 set inputs, ff end
01 00 00 5A 00 00 00 00
01 05 00 5A 00 00 00 00
01 08 00 5A 00 00 00 00
01 1C 80 5A 00 00 00 00
01 1D 80 5A 00 00 00 00
03 00 00 00 A5 3C 96 E1
00 00 FF 5A 00 00 00 00
00 01 12 5A 00 00 00 00
00 05 34 5A 00 00 00 00
00 09 56 5A 00 00 00 00
00 1D 78 5A 00 00 00 00
01 00 FF 5A 00 00 00 00
01 01 12 5A 00 00 00 00
01 09 56 5A 00 00 00 00
01 1D 78 5A 00 00 00 00
01 02 A5 5A 00 00 00 00
01 0A 96 5A 00 00 00 00
01 1E E1 5A 00 00 00 00
01 03 00 5A 00 00 00 00
00 02 77 5A 00 00 00 00
00 10 99 5A 00 00 00 00
01 02 A5 5A 00 00 00 00
01 10 00 5A 00 00 00 00
02 01 00 5A 00 00 00 00
00 05 C3 5A 00 00 00 00
01 01 12 5A 00 00 00 00
01 05 C3 5A 00 00 00 00
FF 00 00 00 00 00 00 00

/* verilog.f */
+incdir+include
rtl/spi2gpio_pkg.sv
rtl/spi_byte_shifter.sv
rtl/spi_cmd_decoder.sv
rtl/gpio_regfile.sv
rtl/spi2gpio.sv
test/tb_spi2gpio.sv

/* Makefile */
SRCS := $(shell grep -v '^+' verilog.f) include/spi2gpio_params.svh

obj_dir/Vtb_spi2gpio: verilog.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_spi2gpio -f verilog.f -o Vtb_spi2gpio

run: obj_dir/Vtb_spi2gpio
	./obj_dir/Vtb_spi2gpio | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
